// File: src/panel_params.svh
// ##################################################################
// LED panel geometry
// ##################################################################

`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// Number of pixel columns on the panel.
`define PANEL_WIDTH 8

// Number of pixel rows on the panel.
`define PANEL_HEIGHT 4

// Color bytes stored for each pixel.
`define BYTES_PER_PIXEL 2

`endif

// File: src/panel_types_pkg.sv
// ##################################################################
// Frame-buffer address and write types
// ##################################################################

`include "panel_params.svh"

package panel_types_pkg;

    localparam int COL_W  = (`PANEL_WIDTH > 1) ? $clog2(`PANEL_WIDTH) : 1;
    localparam int ROW_W  = (`PANEL_HEIGHT > 1) ? $clog2(`PANEL_HEIGHT) : 1;
    localparam int BYTE_W = (`BYTES_PER_PIXEL > 1) ? $clog2(`BYTES_PER_PIXEL) : 1;

    typedef logic [COL_W-1:0]              col_addr_t;
    typedef logic [ROW_W-1:0]              row_addr_t;
    typedef logic [BYTE_W-1:0]             byte_idx_t;
    typedef logic [8*`BYTES_PER_PIXEL-1:0] color_t;

    // One byte-wide write into the frame buffer.
    typedef struct packed {
        logic      valid;
        row_addr_t row;
        col_addr_t column;
        byte_idx_t byte_idx;
        logic [7:0] data;
    } fb_write_t;

endpackage

// File: src/panel_cmd_pkg.sv
// ##################################################################
// Command opcodes, states and payload strobe
// ##################################################################

package panel_cmd_pkg;

    typedef enum logic [7:0] {
        OP_FILLPANEL = 8'h01,
        OP_DRAWPIXEL = 8'h02
    } opcode_t;

    // One payload byte handed from the decoder to an executor.
    typedef struct packed {
        logic       valid;
        logic       first;
        logic [7:0] data;
    } payload_t;

    typedef enum logic [1:0] {FILL_CAPTURE, FILL_RUNNING, FILL_DONE} fill_state_t;

    typedef enum logic [1:0] {DRAW_CAPTURE, DRAW_WRITING, DRAW_DONE} draw_state_t;

    typedef enum logic [1:0] {DEC_IDLE, DEC_PAYLOAD, DEC_BUSY} dec_state_t;

endpackage

// File: src/cmd_decoder.sv
// ##################################################################
// Command byte decoder
// ##################################################################

`timescale 1ns/1ps

`include "panel_params.svh"

module cmd_decoder
    import panel_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       data_strobe,
    input  logic       cmd_done,
    output logic       ready,
    output payload_t   fill_payload,
    output payload_t   draw_payload
);

    localparam int REM_W = $clog2(`BYTES_PER_PIXEL + 3);

    dec_state_t       state;
    opcode_t          cur_op;
    logic [REM_W-1:0] remaining;
    logic             first_byte;
    logic             take_payload;

    assign ready        = (state != DEC_BUSY);
    assign take_payload = data_strobe && (state == DEC_PAYLOAD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= DEC_IDLE;
            cur_op     <= OP_FILLPANEL;
            remaining  <= '0;
            first_byte <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    if (data_strobe) begin
                        first_byte <= 1'b1;
                        case (opcode_t'(data_in))
                            OP_FILLPANEL: begin
                                cur_op    <= OP_FILLPANEL;
                                remaining <= REM_W'(`BYTES_PER_PIXEL);
                                state     <= DEC_PAYLOAD;
                            end
                            OP_DRAWPIXEL: begin
                                cur_op    <= OP_DRAWPIXEL;
                                remaining <= REM_W'(`BYTES_PER_PIXEL + 2);
                                state     <= DEC_PAYLOAD;
                            end
                            // Unknown opcodes are dropped and we stay ready.
                            default: state <= DEC_IDLE;
                        endcase
                    end
                end
                DEC_PAYLOAD: begin
                    if (take_payload) begin
                        first_byte <= 1'b0;
                        remaining  <= remaining - 1'b1;
                        if (remaining == REM_W'(1)) begin
                            state <= DEC_BUSY;
                        end
                    end
                end
                DEC_BUSY: begin
                    if (cmd_done) begin
                        state <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // Payload bytes go out one cycle after their strobe.
    always_ff @(posedge clk) begin
        fill_payload.first <= first_byte;
        fill_payload.data  <= data_in;
        draw_payload.first <= first_byte;
        draw_payload.data  <= data_in;
        if (reset) begin
            fill_payload.valid <= 1'b0;
            draw_payload.valid <= 1'b0;
        end else begin
            fill_payload.valid <= take_payload && (cur_op == OP_FILLPANEL);
            draw_payload.valid <= take_payload && (cur_op == OP_DRAWPIXEL);
        end
    end

endmodule

// File: src/cmd_fillpanel.sv
// ##################################################################
// Fill panel command executor
// ##################################################################

`timescale 1ns/1ps

`include "panel_params.svh"

module cmd_fillpanel
    import panel_types_pkg::*;
    import panel_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  payload_t  payload,
    output fb_write_t fb_write,
    output logic      done
);

    localparam int CAP_W = $clog2(`BYTES_PER_PIXEL + 1);

    fill_state_t      state;
    color_t           color;
    logic [CAP_W-1:0] cap_cnt;
    logic [CAP_W-1:0] cap_idx;
    row_addr_t        row_cnt;
    col_addr_t        col_cnt;
    byte_idx_t        byte_cnt;
    logic             last_byte;
    logic             last_col;
    logic             last_row;

    // A first strobe restarts the byte count even after an aborted capture.
    assign cap_idx = payload.first ? '0 : cap_cnt;

    assign last_byte = (byte_cnt == '0);
    assign last_col  = (col_cnt == col_addr_t'(`PANEL_WIDTH - 1));
    assign last_row  = (row_cnt == row_addr_t'(`PANEL_HEIGHT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FILL_CAPTURE;
            cap_cnt  <= '0;
            row_cnt  <= '0;
            col_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                FILL_CAPTURE: begin
                    if (payload.valid) begin
                        if (cap_idx == CAP_W'(`BYTES_PER_PIXEL - 1)) begin
                            cap_cnt  <= '0;
                            row_cnt  <= '0;
                            col_cnt  <= '0;
                            byte_cnt <= byte_idx_t'(`BYTES_PER_PIXEL - 1);
                            state    <= FILL_RUNNING;
                        end else begin
                            cap_cnt <= cap_idx + 1'b1;
                        end
                    end
                end
                FILL_RUNNING: begin
                    // Bytes high to low, then columns, then rows.
                    if (last_byte) begin
                        byte_cnt <= byte_idx_t'(`BYTES_PER_PIXEL - 1);
                        if (last_col) begin
                            col_cnt <= '0;
                            if (last_row) begin
                                state <= FILL_DONE;
                            end else begin
                                row_cnt <= row_cnt + 1'b1;
                            end
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end else begin
                        byte_cnt <= byte_cnt - 1'b1;
                    end
                end
                FILL_DONE: begin
                    state <= FILL_CAPTURE;
                end
                default: state <= FILL_CAPTURE;
            endcase
        end
    end

    // Color arrives most significant byte first.
    always_ff @(posedge clk) begin
        if (state == FILL_CAPTURE && payload.valid) begin
            color <= (payload.first ? '0 : (color << 8)) | color_t'(payload.data);
        end
    end

    always_comb begin
        fb_write.valid    = (state == FILL_RUNNING);
        fb_write.row      = row_cnt;
        fb_write.column   = col_cnt;
        fb_write.byte_idx = byte_cnt;
        fb_write.data     = color[8*byte_cnt +: 8];
    end

    assign done = (state == FILL_DONE);

endmodule

// File: src/cmd_drawpixel.sv
// ##################################################################
// Draw pixel command executor
// ##################################################################

`timescale 1ns/1ps

`include "panel_params.svh"

module cmd_drawpixel
    import panel_types_pkg::*;
    import panel_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  payload_t  payload,
    output fb_write_t fb_write,
    output logic      done
);

    localparam int CAP_W = $clog2(`BYTES_PER_PIXEL + 3);

    draw_state_t      state;
    logic [CAP_W-1:0] cap_cnt;
    logic [CAP_W-1:0] cap_idx;
    logic [7:0]       col_raw;
    logic [7:0]       row_raw;
    color_t           color;
    byte_idx_t        byte_cnt;
    logic             in_range;

    assign cap_idx  = payload.first ? '0 : cap_cnt;
    assign in_range = (col_raw < `PANEL_WIDTH) && (row_raw < `PANEL_HEIGHT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DRAW_CAPTURE;
            cap_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                DRAW_CAPTURE: begin
                    if (payload.valid) begin
                        if (cap_idx == CAP_W'(`BYTES_PER_PIXEL + 1)) begin
                            cap_cnt  <= '0;
                            byte_cnt <= byte_idx_t'(`BYTES_PER_PIXEL - 1);
                            // Off-panel coordinates skip straight to done.
                            state    <= in_range ? DRAW_WRITING : DRAW_DONE;
                        end else begin
                            cap_cnt <= cap_idx + 1'b1;
                        end
                    end
                end
                DRAW_WRITING: begin
                    if (byte_cnt == '0) begin
                        state <= DRAW_DONE;
                    end else begin
                        byte_cnt <= byte_cnt - 1'b1;
                    end
                end
                DRAW_DONE: begin
                    state <= DRAW_CAPTURE;
                end
                default: state <= DRAW_CAPTURE;
            endcase
        end
    end

    // Byte order is column, row, then color most significant first.
    always_ff @(posedge clk) begin
        if (state == DRAW_CAPTURE && payload.valid) begin
            if (cap_idx == '0) begin
                col_raw <= payload.data;
            end else if (cap_idx == CAP_W'(1)) begin
                row_raw <= payload.data;
            end else begin
                color <= (color << 8) | color_t'(payload.data);
            end
        end
    end

    always_comb begin
        fb_write.valid    = (state == DRAW_WRITING);
        fb_write.row      = row_addr_t'(row_raw);
        fb_write.column   = col_addr_t'(col_raw);
        fb_write.byte_idx = byte_cnt;
        fb_write.data     = color[8*byte_cnt +: 8];
    end

    assign done = (state == DRAW_DONE);

endmodule

// File: src/fb_write_combiner.sv
// ##################################################################
// Frame-buffer write combiner
// ##################################################################

`timescale 1ns/1ps

module fb_write_combiner
    import panel_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  fb_write_t fill_write,
    input  fb_write_t draw_write,
    input  logic      fill_done,
    input  logic      draw_done,
    output fb_write_t fb_write,
    output logic      cmd_done
);

    fb_write_t selected;

    // Only one executor runs at a time, so the priority rarely matters.
    assign selected = fill_write.valid ? fill_write : draw_write;

    always_ff @(posedge clk) begin
        fb_write.row      <= selected.row;
        fb_write.column   <= selected.column;
        fb_write.byte_idx <= selected.byte_idx;
        fb_write.data     <= selected.data;
        if (reset) begin
            fb_write.valid <= 1'b0;
            cmd_done       <= 1'b0;
        end else begin
            fb_write.valid <= selected.valid;
            cmd_done       <= fill_done | draw_done;
        end
    end

endmodule

// File: src/panel_cmd_top.sv
// ##################################################################
// LED panel command subsystem
// ##################################################################

`timescale 1ns/1ps

module panel_cmd_top
    import panel_types_pkg::*;
    import panel_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       data_strobe,
    output logic       ready,
    output fb_write_t  fb_write,
    output logic       cmd_done
);

    payload_t  fill_payload;
    payload_t  draw_payload;
    fb_write_t fill_write;
    fb_write_t draw_write;
    logic      fill_done;
    logic      draw_done;

    cmd_decoder decoder (
        .clk          (clk),
        .reset        (reset),
        .data_in      (data_in),
        .data_strobe  (data_strobe),
        .cmd_done     (cmd_done),
        .ready        (ready),
        .fill_payload (fill_payload),
        .draw_payload (draw_payload)
    );

    cmd_fillpanel fillpanel (
        .clk      (clk),
        .reset    (reset),
        .payload  (fill_payload),
        .fb_write (fill_write),
        .done     (fill_done)
    );

    cmd_drawpixel drawpixel (
        .clk      (clk),
        .reset    (reset),
        .payload  (draw_payload),
        .fb_write (draw_write),
        .done     (draw_done)
    );

    fb_write_combiner combiner (
        .clk        (clk),
        .reset      (reset),
        .fill_write (fill_write),
        .draw_write (draw_write),
        .fill_done  (fill_done),
        .draw_done  (draw_done),
        .fb_write   (fb_write),
        .cmd_done   (cmd_done)
    );

endmodule

// File: test/panel_cmd_checker.sv
// ##################################################################
// Panel command protocol assertions
// ##################################################################

`timescale 1ns/1ps

module panel_cmd_checker
    import panel_types_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      ready,
    input fb_write_t fb_write,
    input logic      cmd_done
);

    // Writes only come out while a command holds ready low.
    write_while_busy: assert property (@(posedge clk) disable iff (reset)
        fb_write.valid |-> !ready)
        else $error("fb_write.valid is high while ready is high");

    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        cmd_done |=> !cmd_done)
        else $error("cmd_done stayed high for more than one cycle");

    ready_after_done: assert property (@(posedge clk) disable iff (reset)
        $rose(ready) |-> $past(cmd_done))
        else $error("ready rose without cmd_done one cycle before");

endmodule

bind panel_cmd_top panel_cmd_checker panel_checker (
    .clk      (clk),
    .reset    (reset),
    .ready    (ready),
    .fb_write (fb_write),
    .cmd_done (cmd_done)
);

// File: test/panel_cmd_tb.sv
// ##################################################################
// Panel command testbench
// ##################################################################

`timescale 1ns/1ps

`include "panel_params.svh"

module panel_cmd_tb
    import panel_types_pkg::*;
    import panel_cmd_pkg::*;
();

    localparam int    BPP       = `BYTES_PER_PIXEL;
    localparam int    IDLE_WAIT = 10;
    localparam string CASE_FILE = "test/panel_cmd_cases.txt";

    logic       clk;
    logic       reset;
    logic [7:0] data_in;
    logic       data_strobe;
    logic       ready;
    fb_write_t  fb_write;
    logic       cmd_done;

    logic [7:0] case_bytes[$];
    int         case_len[$];
    fb_write_t  expect_q[$];
    int         error_count  = 0;
    int         cycle_count  = 0;
    int         cycle_limit  = 0;
    int         writes_total = 0;
    int         dones_total  = 0;

    panel_cmd_top UUT (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .data_strobe (data_strobe),
        .ready       (ready),
        .fb_write    (fb_write),
        .cmd_done    (cmd_done)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
        end
    endtask

    task automatic read_cases();
        int    fd;
        int    code;
        int    count;
        int    value;
        bit    at_end;
        string token;
        string rest;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            fail_run({"Could not open the case file ", CASE_FILE});
        end
        at_end = 1'b0;
        while (!at_end) begin
            code = $fscanf(fd, "%s", token);
            if (code != 1) begin
                at_end = 1'b1;
            end else if (token.getc(0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                count = token.atoi();
                for (int k = 0; k < count; k++) begin
                    code = $fscanf(fd, "%h", value);
                    if (code != 1) begin
                        fail_run("The case file has a line with fewer bytes than its count");
                    end
                    case_bytes.push_back(8'(value));
                end
                case_len.push_back(count);
            end
        end
        $fclose(fd);
    endtask

    task automatic expect_write(input bit push, input int row, input int col,
                                input int byte_idx, input logic [7:0] data,
                                inout int n_writes);
        fb_write_t w;
        w.valid    = 1'b1;
        w.row      = row_addr_t'(row);
        w.column   = col_addr_t'(col);
        w.byte_idx = byte_idx_t'(byte_idx);
        w.data     = data;
        n_writes++;
        if (push) begin
            expect_q.push_back(w);
        end
    endtask

    // Unknown bytes before the opcode are dropped. Bytes after a full command are ignored.
    task automatic model_case(input int first, input int len, input bit push,
                              output int n_writes, output bit has_cmd);
        logic [7:0] cmd_bytes[$];
        opcode_t    op;
        int         need;
        bit         in_cmd;
        n_writes = 0;
        has_cmd  = 1'b0;
        in_cmd   = 1'b0;
        need     = 0;
        op       = OP_FILLPANEL;
        for (int i = 0; i < len; i++) begin
            if (!in_cmd) begin
                if (case_bytes[first + i] == OP_FILLPANEL) begin
                    op     = OP_FILLPANEL;
                    need   = BPP;
                    in_cmd = 1'b1;
                end else if (case_bytes[first + i] == OP_DRAWPIXEL) begin
                    op     = OP_DRAWPIXEL;
                    need   = BPP + 2;
                    in_cmd = 1'b1;
                end
            end else if (!has_cmd) begin
                cmd_bytes.push_back(case_bytes[first + i]);
                has_cmd = (cmd_bytes.size() == need);
            end
        end
        if (in_cmd && !has_cmd) begin
            fail_run($sformatf("The case at byte %0d ends inside a command", first));
        end
        if (has_cmd && op == OP_FILLPANEL) begin
            for (int r = 0; r < `PANEL_HEIGHT; r++) begin
                for (int c = 0; c < `PANEL_WIDTH; c++) begin
                    for (int b = BPP - 1; b >= 0; b--) begin
                        expect_write(push, r, c, b, cmd_bytes[BPP - 1 - b], n_writes);
                    end
                end
            end
        end else if (has_cmd && int'(cmd_bytes[0]) < `PANEL_WIDTH
                     && int'(cmd_bytes[1]) < `PANEL_HEIGHT) begin
            for (int b = BPP - 1; b >= 0; b--) begin
                expect_write(push, int'(cmd_bytes[1]), int'(cmd_bytes[0]), b,
                             cmd_bytes[BPP + 1 - b], n_writes);
            end
        end
    endtask

    task automatic run_case(input int first, input int len);
        int n_writes;
        bit has_cmd;
        int start_writes;
        int start_dones;
        model_case(first, len, 1'b1, n_writes, has_cmd);
        start_writes = writes_total;
        start_dones  = dones_total;
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            data_in     = case_bytes[first + i];
            data_strobe = 1'b1;
        end
        @(negedge clk);
        data_in     = 8'h00;
        data_strobe = 1'b0;
        if (has_cmd) begin
            while (cmd_done !== 1'b1) @(negedge clk);
            while (ready !== 1'b1) @(negedge clk);
        end else begin
            repeat (IDLE_WAIT) @(negedge clk);
        end
        check_value("write count", writes_total - start_writes, n_writes);
        check_value("cmd_done count", dones_total - start_dones, 32'(has_cmd));
        check_value("pending writes", expect_q.size(), 0);
        check_value("ready", 32'(ready), 32'd1);
    endtask

    // Registered outputs are stable at the falling edge.
    always @(negedge clk) begin : output_monitor
        fb_write_t expected;
        if (!reset) begin
            if (fb_write.valid === 1'b1) begin
                if (expect_q.size() == 0) begin
                    fail_run("A frame-buffer write appeared when none was expected");
                end else begin
                    expected = expect_q.pop_front();
                    check_value("fb_write.row", 32'(fb_write.row), 32'(expected.row));
                    check_value("fb_write.column", 32'(fb_write.column),
                                32'(expected.column));
                    check_value("fb_write.byte_idx", 32'(fb_write.byte_idx),
                                32'(expected.byte_idx));
                    check_value("fb_write.data", 32'(fb_write.data), 32'(expected.data));
                    writes_total++;
                end
            end
            if (cmd_done === 1'b1) begin
                dones_total++;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                fail_run($sformatf("Timeout: the run went past its limit of %0d cycles",
                                   cycle_limit));
            end
        end
    end

    initial begin
        int n_writes;
        bit has_cmd;
        int first;
        int budget;
        clk         = 1'b0;
        reset       = 1'b1;
        data_in     = 8'h00;
        data_strobe = 1'b0;
        read_cases();
        first  = 0;
        budget = 0;
        foreach (case_len[i]) begin
            model_case(first, case_len[i], 1'b0, n_writes, has_cmd);
            budget += n_writes + 10;
            first  += case_len[i];
        end
        cycle_limit = 4 * budget;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (IDLE_WAIT) @(negedge clk);
        check_value("ready", 32'(ready), 32'd1);
        check_value("writes after reset", writes_total, 0);
        check_value("cmd_done after reset", dones_total, 0);
        first = 0;
        foreach (case_len[i]) begin
            run_case(first, case_len[i]);
            first += case_len[i];
        end
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/panel_types_pkg.sv
src/panel_cmd_pkg.sv
src/cmd_decoder.sv
src/cmd_fillpanel.sv
src/cmd_drawpixel.sv
src/fb_write_combiner.sv
src/panel_cmd_top.sv
test/panel_cmd_checker.sv
test/panel_cmd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= panel_cmd_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTS PASSED
FAIL_MSG  ?= TESTS FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/panel_cmd_cases.txt
# Each line: byte count (decimal), then the bytes in hex, opcode first.
# 01 = fill panel (color), 02 = draw pixel (column, row, color), others unknown.
3 01 12 34
5 02 00 00 AB CD
5 02 07 03 5A A5
5 02 03 01 FF 00
# Off-panel draws write nothing but still finish.
5 02 08 00 11 22
5 02 00 04 33 44
5 02 FF FF 55 66
# Unknown opcodes alone, then one in front of a fill.
1 A5
1 00
4 7E 01 C3 3C
# The draw bytes after this fill are strobed while ready is low.
7 01 0F F0 02 01 01 EE
5 02 05 02 DE AD
3 01 00 00
5 02 04 02 BE EF
5 02 07 00 80 01
